//--- Makefile
TOP = fpAddSubTb

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q ">>> FAIL" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module fpAddSub

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- compile.f
rtl/fpFormatPkg.sv
rtl/fpPipePkg.sv
rtl/fpPrealign.sv
rtl/fpAlign.sv
rtl/fpExecute.sv
rtl/fpNormalize.sv
rtl/fpRoundPack.sv
rtl/fpAddSub.sv
verif/fpAddSub_props.sv
verif/fpAddSubTb.sv

//--- rtl/fpAddSub.sv
`timescale 1ns/1ps

module fpAddSub (
	input  logic              clk,
	input  logic              arstN,
	input  logic              inVld,
	input  fpFormatPkg::halfT a,
	input  fpFormatPkg::halfT b,
	input  logic              sub,     // 1 = a - b
	output logic              outVld,
	output fpFormatPkg::halfT y,
	output fpFormatPkg::excT  exc
);

	fpPipePkg::preT pre;  // Stage 1 out
	fpPipePkg::alnT aln;  // Stage 2 out
	fpPipePkg::exeT exe;  // Stage 3 out
	fpPipePkg::nrmT nrm;  // Stage 4 out

	fpPrealign uPrealign (
		.clk(clk), .arstN(arstN), .inVld(inVld), .a(a), .b(b), .sub(sub), .pre(pre)
	);

	fpAlign uAlign (
		.clk(clk), .arstN(arstN), .pre(pre), .aln(aln)
	);

	fpExecute uExecute (
		.clk(clk), .arstN(arstN), .aln(aln), .exe(exe)
	);

	fpNormalize uNormalize (
		.clk(clk), .arstN(arstN), .exe(exe), .nrm(nrm)
	);

	fpRoundPack uRoundPack (
		.clk(clk), .arstN(arstN), .nrm(nrm), .outVld(outVld), .y(y), .exc(exc)
	);

endmodule

//--- rtl/fpAlign.sv
`timescale 1ns/1ps

module fpAlign (
	input  logic           clk,
	input  logic           arstN,
	input  fpPipePkg::preT pre,
	output fpPipePkg::alnT aln
);

	logic aBig;                                   // A has the larger magnitude
	fpPipePkg::magT bigMag;
	fpPipePkg::magT smallMag;
	logic [fpFormatPkg::expWidth-1:0] shiftAmt;   // Exponent gap
	fpPipePkg::sigT smallSig;
	fpPipePkg::extT smallExt;
	fpPipePkg::extT shifted;
	fpPipePkg::extT lostMask;                     // Bits pushed out the bottom
	fpPipePkg::alnT alnD;
	fpPipePkg::alnT alnQ;
	logic vldQ;

	// Exp sits above man, so a plain compare orders by magnitude
	// Tie keeps a on top
	assign aBig     = pre.aMag >= pre.bMag;
	assign bigMag   = aBig ? pre.aMag : pre.bMag;
	assign smallMag = aBig ? pre.bMag : pre.aMag;
	assign shiftAmt = aBig ? pre.shiftDet[fpFormatPkg::expWidth-1:0]     // A-B
	                       : pre.shiftDet[2*fpFormatPkg::expWidth-1:fpFormatPkg::expWidth];  // B-A

	// Hidden one only for non-zero exponent
	assign smallSig = {|smallMag[fpPipePkg::magWidth-1:fpFormatPkg::manWidth],
	                   smallMag[fpFormatPkg::manWidth-1:0]};
	assign smallExt = {smallSig, 3'b000};
	assign shifted  = smallExt >> shiftAmt;
	assign lostMask = (fpPipePkg::extT'(1) << shiftAmt) - fpPipePkg::extT'(1);  // All ones past 13

	always_comb begin
		alnD.sign     = aBig ? pre.sa : (pre.sb ^ pre.op);
		alnD.exp      = bigMag[fpPipePkg::magWidth-1:fpFormatPkg::manWidth];
		alnD.bigSig   = {|bigMag[fpPipePkg::magWidth-1:fpFormatPkg::manWidth],
		                 bigMag[fpFormatPkg::manWidth-1:0]};
		alnD.smallSig = {shifted[fpPipePkg::extWidth-1:1],
		                 shifted[0] | (|(smallExt & lostMask))};  // Sticky collects the rest
		alnD.effSub   = pre.sa ^ pre.sb ^ pre.op;
		alnD.exc      = pre.exc;
		alnD.vld      = pre.vld;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vldQ <= 1'b0;
		end else begin
			vldQ <= pre.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (pre.vld) alnQ <= alnD;
	end

	always_comb begin
		aln     = alnQ;
		aln.vld = vldQ;
	end

endmodule

//--- rtl/fpExecute.sv
`timescale 1ns/1ps

module fpExecute (
	input  logic           clk,
	input  logic           arstN,
	input  fpPipePkg::alnT aln,
	output fpPipePkg::exeT exe
);

	fpPipePkg::extT bigExt;   // Large sig with empty GRS
	fpPipePkg::sumT sumD;
	fpPipePkg::exeT exeD;
	fpPipePkg::exeT exeQ;
	logic vldQ;

	assign bigExt = {aln.bigSig, 3'b000};

	// Large minus small never goes negative
	assign sumD = aln.effSub ? ({1'b0, bigExt} - {1'b0, aln.smallSig})
	                         : ({1'b0, bigExt} + {1'b0, aln.smallSig});

	always_comb begin
		// Exact cancel gives +0, (-0)+(-0) stays -0
		exeD.sign = (sumD == '0 && aln.effSub) ? 1'b0 : aln.sign;
		exeD.exp  = aln.exp;
		exeD.sum  = sumD;
		exeD.exc  = aln.exc;
		exeD.vld  = aln.vld;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vldQ <= 1'b0;
		end else begin
			vldQ <= aln.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (aln.vld) exeQ <= exeD;
	end

	always_comb begin
		exe     = exeQ;
		exe.vld = vldQ;
	end

endmodule

//--- rtl/fpFormatPkg.sv
package fpFormatPkg;

	localparam int expWidth  = 5;                        // Exponent field
	localparam int manWidth  = 10;                       // Stored mantissa, no hidden bit
	localparam int dataWidth = 1 + expWidth + manWidth;  // Whole half word
	localparam int expBias   = 15;                       // Exponent offset
	localparam int expMax    = (1 << expWidth) - 1;      // All-ones code, inf or NaN

	// Half-precision word split into its fields
	typedef struct packed {
		logic                sign;  // 1 = negative
		logic [expWidth-1:0] exp;   // Biased exponent
		logic [manWidth-1:0] man;   // Fraction bits
	} halfT;

	// Input exception vector, same flag order as the prealign block
	typedef struct packed {
		logic anyExc;  // Some operand is inf or NaN
		logic aNaN;    // A is NaN
		logic bNaN;    // B is NaN
		logic aInf;    // A is infinity
		logic bInf;    // B is infinity
	} excT;

	// Canonical quiet NaN, 0x7E00
	localparam halfT qNaN = '{
		sign: 1'b0,
		exp:  {expWidth{1'b1}},
		man:  {1'b1, {(manWidth-1){1'b0}}}
	};

endpackage

//--- rtl/fpNormalize.sv
`timescale 1ns/1ps

module fpNormalize (
	input  logic           clk,
	input  logic           arstN,
	input  fpPipePkg::exeT exe,
	output fpPipePkg::nrmT nrm
);

	logic carry;                                  // Sum reached 2.0 or more
	logic [3:0] lz;                               // Leading zeros below carry
	logic signed [fpPipePkg::nexpWidth-1:0] expIn;
	fpPipePkg::nrmT nrmD;
	fpPipePkg::nrmT nrmQ;
	logic vldQ;

	assign carry = exe.sum[fpPipePkg::extWidth];
	assign expIn = $signed({2'b00, exe.exp});

	// Priority encode, highest set bit wins
	always_comb begin
		lz = 4'(fpPipePkg::extWidth);
		for (int i = 0; i < fpPipePkg::extWidth; i++) begin
			if (exe.sum[i]) lz = 4'(fpPipePkg::extWidth - 1 - i);
		end
	end

	always_comb begin
		if (carry) begin
			nrmD.sig = {exe.sum[fpPipePkg::extWidth:2], exe.sum[1] | exe.sum[0]};  // Keep sticky
			nrmD.exp = expIn + 7'sd1;
		end else begin
			nrmD.sig = exe.sum[fpPipePkg::extWidth-1:0] << lz;  // Only exact bits move up
			nrmD.exp = expIn - $signed({3'b000, lz});
		end
		nrmD.sign = exe.sign;
		nrmD.zero = (exe.sum == '0);
		nrmD.exc  = exe.exc;
		nrmD.vld  = exe.vld;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vldQ <= 1'b0;
		end else begin
			vldQ <= exe.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (exe.vld) nrmQ <= nrmD;
	end

	always_comb begin
		nrm     = nrmQ;
		nrm.vld = vldQ;
	end

endmodule

//--- rtl/fpPipePkg.sv
package fpPipePkg;

	localparam int magWidth  = fpFormatPkg::dataWidth - 1;  // Exp and man without sign
	localparam int sigWidth  = fpFormatPkg::manWidth + 1;   // With hidden one
	localparam int extWidth  = sigWidth + 3;                // Plus guard, round, sticky
	localparam int nexpWidth = fpFormatPkg::expWidth + 2;   // Signed, room for under/overflow

	typedef logic [magWidth-1:0] magT;
	typedef logic [sigWidth-1:0] sigT;
	typedef logic [extWidth-1:0] extT;
	typedef logic [extWidth:0]   sumT;  // Carry on top

	// Prealign -> align
	typedef struct packed {
		logic sa;                                        // Sign of a
		logic sb;                                        // Sign of b
		magT  aMag;                                      // Zero when exp is zero
		magT  bMag;
		logic [2*fpFormatPkg::expWidth-1:0] shiftDet;    // {B-A, A-B}
		fpFormatPkg::excT exc;
		logic op;                                        // 1 = subtract
		logic vld;
	} preT;

	// Align -> execute
	typedef struct packed {
		logic sign;                            // Sign of large operand, b flipped on sub
		logic [fpFormatPkg::expWidth-1:0] exp; // Common exponent
		sigT  bigSig;                          // Large significand
		extT  smallSig;                        // Small one, shifted, with GRS
		logic effSub;                          // Effective subtraction
		fpFormatPkg::excT exc;
		logic vld;
	} alnT;

	// Execute -> normalize
	typedef struct packed {
		logic sign;
		logic [fpFormatPkg::expWidth-1:0] exp;
		sumT  sum;                             // Raw sum incl. carry
		fpFormatPkg::excT exc;
		logic vld;
	} exeT;

	// Normalize -> round/pack
	typedef struct packed {
		logic sign;
		logic signed [nexpWidth-1:0] exp;      // Adjusted exponent
		extT  sig;                             // Hidden one at MSB, GRS at bottom
		logic zero;                            // Exact zero sum
		fpFormatPkg::excT exc;
		logic vld;
	} nrmT;

endpackage

//--- rtl/fpPrealign.sv
`timescale 1ns/1ps

module fpPrealign (
	input  logic              clk,
	input  logic              arstN,
	input  logic              inVld,
	input  fpFormatPkg::halfT a,
	input  fpFormatPkg::halfT b,
	input  logic              sub,
	output fpPipePkg::preT    pre
);

	logic aExpOnes;          // Exponent all ones
	logic bExpOnes;
	logic aManNz;            // Fraction non-zero
	logic bManNz;
	fpPipePkg::preT preD;    // Next stage value
	fpPipePkg::preT preQ;
	logic vldQ;

	assign aExpOnes = &a.exp;
	assign bExpOnes = &b.exp;
	assign aManNz   = |a.man;
	assign bManNz   = |b.man;

	always_comb begin
		preD.sa        = a.sign;
		preD.sb        = b.sign;
		preD.aMag      = (a.exp == '0) ? '0 : {a.exp, a.man};  // Subnormal flush
		preD.bMag      = (b.exp == '0) ? '0 : {b.exp, b.man};
		preD.shiftDet  = {b.exp - a.exp, a.exp - b.exp};       // Both ways, picked later
		preD.exc.aNaN  = aExpOnes & aManNz;
		preD.exc.bNaN  = bExpOnes & bManNz;
		preD.exc.aInf  = aExpOnes & ~aManNz;
		preD.exc.bInf  = bExpOnes & ~bManNz;
		preD.exc.anyExc = aExpOnes | bExpOnes;                 // Any of the four above
		preD.op        = sub;
		preD.vld       = inVld;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vldQ <= 1'b0;
		end else begin
			vldQ <= inVld;
		end
	end

	always_ff @(posedge clk) begin
		if (inVld) preQ <= preD;  // Payload only on valid
	end

	always_comb begin
		pre     = preQ;
		pre.vld = vldQ;
	end

endmodule

//--- rtl/fpRoundPack.sv
`timescale 1ns/1ps

module fpRoundPack (
	input  logic              clk,
	input  logic              arstN,
	input  fpPipePkg::nrmT    nrm,
	output logic              outVld,
	output fpFormatPkg::halfT y,
	output fpFormatPkg::excT  exc
);

	logic lsb;                                   // Last kept bit
	logic guard;
	logic sticky;                                // Round and sticky merged
	logic rndUp;
	logic [fpPipePkg::sigWidth:0] rounded;      // Sig plus carry out
	logic rndCarry;                              // Rounding wrapped to 2.0
	logic signed [fpPipePkg::nexpWidth-1:0] expR;
	fpFormatPkg::halfT res;

	assign lsb     = nrm.sig[3];
	assign guard   = nrm.sig[2];
	assign sticky  = |nrm.sig[1:0];
	assign rndUp   = guard & (sticky | lsb);     // Nearest, ties to even
	assign rounded = {1'b0, nrm.sig[fpPipePkg::extWidth-1:3]}
	               + {{fpPipePkg::sigWidth{1'b0}}, rndUp};
	assign rndCarry = rounded[fpPipePkg::sigWidth];
	assign expR     = rndCarry ? (nrm.exp + 7'sd1) : nrm.exp;

	always_comb begin
		res.sign = nrm.sign;
		res.exp  = expR[fpFormatPkg::expWidth-1:0];
		res.man  = rndCarry ? rounded[fpFormatPkg::manWidth:1]    // Mantissa all zero again
		                    : rounded[fpFormatPkg::manWidth-1:0];
		if (nrm.exc.aNaN | nrm.exc.bNaN) begin
			res = fpFormatPkg::qNaN;
		end else if (nrm.exc.aInf & nrm.exc.bInf & nrm.zero) begin
			res = fpFormatPkg::qNaN;                 // Inf - inf cancelled
		end else if (nrm.exc.aInf | nrm.exc.bInf) begin
			res.exp = '1;                            // Sign already from the inf side
			res.man = '0;
		end else if (nrm.zero) begin
			res.exp = '0;
			res.man = '0;
		end else if (expR >= fpFormatPkg::expMax) begin
			res.exp = '1;                            // Overflow to inf
			res.man = '0;
		end else if (expR < 1) begin
			res.exp = '0;                            // Flush, sign kept
			res.man = '0;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outVld <= 1'b0;
		end else begin
			outVld <= nrm.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (nrm.vld) begin
			y   <= res;
			exc <= nrm.exc;  // Input flags, five cycles late
		end
	end

endmodule

//--- verif/fpAddSubTb.sv
`timescale 1ns/1ps

module fpAddSubTb;

	logic clk;
	logic arstN;
	logic inVld;
	logic sub;
	logic outVld;
	fpFormatPkg::halfT a;
	fpFormatPkg::halfT b;
	fpFormatPkg::halfT y;
	fpFormatPkg::excT  exc;

	fpFormatPkg::halfT yQ[$];    // Expected results, issue order
	fpFormatPkg::excT  excQ[$];
	string curTest;
	int seed;
	int valErrs;                 // Wrong values
	int otherErrs;               // Timeouts, stray strobes

	fpAddSub u_dut (
		.clk(clk), .arstN(arstN), .inVld(inVld), .a(a), .b(b), .sub(sub),
		.outVld(outVld), .y(y), .exc(exc)
	);

	bind fpAddSub fpAddSubProps uProps (
		.clk(clk), .arstN(arstN), .inVld(inVld), .outVld(outVld), .y(y), .exc(exc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic real pow2(input int n);
		real r;
		r = 1.0;
		for (int i = 0; i < n; i++) r = r * 2.0;
		for (int i = 0; i > n; i--) r = r / 2.0;
		return r;
	endfunction

	function automatic real halfToReal(input fpFormatPkg::halfT h);
		real v;
		if (h.exp == 0) return 0.0;                       // Subnormals count as zero
		v = (1024.0 + h.man) * pow2(int'(h.exp) - 25);
		return h.sign ? -v : v;
	endfunction

	// Nearest even at 11 bits, then range limits
	function automatic fpFormatPkg::halfT realToHalf(input real r);
		fpFormatPkg::halfT h;
		real m;
		real scaled;
		real frac;
		int e;
		int ip;
		h = '0;
		h.sign = (r < 0.0);
		m = h.sign ? -r : r;
		e = 0;
		while (m >= pow2(e + 1)) e++;
		while (m < pow2(e)) e--;
		scaled = m / pow2(e - 10);                         // Now in [1024, 2048)
		ip = $rtoi(scaled);
		frac = scaled - ip;
		if (frac > 0.5 || (frac == 0.5 && ip % 2 == 1)) ip++;
		if (ip == 2048) begin
			ip = 1024;
			e++;
		end
		if (e > 15) begin
			h.exp = '1;                                    // Overflow to inf
		end else if (e >= -14) begin
			h.exp = 5'(e + 15);
			h.man = 10'(ip - 1024);
		end
		return h;
	endfunction

	function automatic fpFormatPkg::excT expectExc(input fpFormatPkg::halfT x,
	                                                input fpFormatPkg::halfT z);
		fpFormatPkg::excT e;
		e.aNaN   = (x.exp == 5'h1F) && (x.man != 0);
		e.bNaN   = (z.exp == 5'h1F) && (z.man != 0);
		e.aInf   = (x.exp == 5'h1F) && (x.man == 0);
		e.bInf   = (z.exp == 5'h1F) && (z.man == 0);
		e.anyExc = (x.exp == 5'h1F) || (z.exp == 5'h1F);
		return e;
	endfunction

	function automatic fpFormatPkg::halfT expectY(input fpFormatPkg::halfT x,
	                                               input fpFormatPkg::halfT z, input logic op);
		fpFormatPkg::excT e;
		fpFormatPkg::halfT h;
		logic bs;
		real s;
		e = expectExc(x, z);
		bs = z.sign ^ op;                                  // Effective sign of b
		h = '0;
		if (e.aNaN || e.bNaN) return fpFormatPkg::qNaN;
		if (e.aInf && e.bInf && (x.sign != bs)) return fpFormatPkg::qNaN;
		if (e.aInf || e.bInf) begin
			h.sign = e.aInf ? x.sign : bs;
			h.exp = '1;
			return h;
		end
		s = halfToReal(x) + (op ? -halfToReal(z) : halfToReal(z));
		if (s == 0.0) begin
			h.sign = (x.exp == 0) && (z.exp == 0) && x.sign && bs;  // Only -0 + -0
			return h;
		end
		return realToHalf(s);
	endfunction

	task automatic checkHalf(input string name, input fpFormatPkg::halfT expV,
	                         input fpFormatPkg::halfT act);
		if (act !== expV) begin
			valErrs++;
			$display("ERR %s expected %h actual %h", name, expV, act);
		end
	endtask

	task automatic checkExc(input string name, input fpFormatPkg::excT expV,
	                        input fpFormatPkg::excT act);
		if (act !== expV) begin
			valErrs++;
			$display("ERR %s exc expected %b actual %b", name, expV, act);
		end
	endtask

	task automatic issue(input fpFormatPkg::halfT x, input fpFormatPkg::halfT z, input logic op);
		@(posedge clk);
		a <= x;
		b <= z;
		sub <= op;
		inVld <= 1'b1;
		yQ.push_back(expectY(x, z, op));
		excQ.push_back(expectExc(x, z));
	endtask

	task automatic idle();
		@(posedge clk);
		inVld <= 1'b0;
	endtask

	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		while (yQ.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (yQ.size() != 0) begin
			otherErrs++;
			$display("Timeout: %s waited too long for its results", curTest);
			yQ.delete();
			excQ.delete();
		end
	endtask

	// Pops one expected entry per result strobe
	always @(negedge clk) begin
		if (arstN && outVld) begin
			if (yQ.size() == 0) begin
				otherErrs++;
				$display("%s: outVld went high with no operation in flight", curTest);
			end else begin
				checkHalf(curTest, yQ.pop_front(), y);
				checkExc(curTest, excQ.pop_front(), exc);
			end
		end
	end

	task automatic testLatency();
		int seen;
		curTest = "testLatency";
		for (int n = 0; n < 8; n++) begin
			@(negedge clk);
			if (outVld) begin
				otherErrs++;
				$display("outVld pulsed after reset with nothing issued");
			end
		end
		issue(16'h3C00, 16'h4000, 1'b0);                   // 1 + 2
		seen = 0;
		for (int n = 1; n <= 12 && seen == 0; n++) begin
			@(posedge clk);
			inVld <= 1'b0;
			@(negedge clk);
			if (outVld) seen = n;
		end
		if (seen == 0) begin
			otherErrs++;
			$display("Timeout: testLatency never saw outVld");
		end else if (seen != 5) begin
			valErrs++;
			$display("ERR testLatency expected 5 actual %0d", seen);
		end
		waitDrain(20);
	endtask

	task automatic testExact();
		curTest = "testExact";
		issue(16'h3C00, 16'h3C00, 1'b0);                   // 1 + 1
		issue(16'h4200, 16'h3C00, 1'b1);                   // 3 - 1
		issue(16'h4500, 16'h4500, 1'b1);                   // x - x gives +0
		issue(16'h8000, 16'h8000, 1'b0);                   // -0 + -0
		issue(16'hC100, 16'h3800, 1'b0);                   // -2.5 + 0.5
		idle();
		waitDrain(20);
	endtask

	task automatic testRounding();
		curTest = "testRounding";
		issue(16'h3C00, 16'h1000, 1'b0);                   // Tie, stays even
		issue(16'h3C01, 16'h1000, 1'b0);                   // Tie, up to even
		issue(16'h3C00, 16'h1001, 1'b0);                   // Just past half
		issue(16'h3FFF, 16'h1000, 1'b0);                   // Carry into exponent
		issue(16'h3C00, 16'h1001, 1'b1);                   // Borrow with sticky
		issue(16'h7000, 16'h3C00, 1'b0);                   // Whole operand in sticky
		idle();
		waitDrain(20);
	endtask

	task automatic testExceptions();
		curTest = "testExceptions";
		issue(16'h7E01, 16'h3C00, 1'b0);                   // NaN a
		issue(16'h3C00, 16'hFC10, 1'b1);                   // NaN b
		issue(16'h7C00, 16'h7C00, 1'b1);                   // inf - inf
		issue(16'h7C00, 16'hFC00, 1'b0);
		issue(16'h7C00, 16'h3C00, 1'b0);                   // inf + 1
		issue(16'h3C00, 16'h7C00, 1'b1);                   // 1 - inf
		issue(16'h7BFF, 16'h7BFF, 1'b0);                   // Overflow
		issue(16'hFBFF, 16'h7BFF, 1'b1);
		issue(16'h0400, 16'h0401, 1'b1);                   // Underflow, negative
		issue(16'h0600, 16'h0400, 1'b1);
		idle();
		waitDrain(20);
	endtask

	task automatic testStream();
		fpFormatPkg::halfT x;
		fpFormatPkg::halfT z;
		int r;
		curTest = "testStream";
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			x = {r[15], 5'(((r >> 10) & 31) % 30 + 1), r[9:0]};  // Normal only
			r = $random(seed);
			z = {r[15], 5'(((r >> 10) & 31) % 30 + 1), r[9:0]};
			issue(x, z, r[20]);
		end
		idle();
		waitDrain(20);
	endtask

	initial begin
		seed = 99684;
		valErrs = 0;
		otherErrs = 0;
		curTest = "reset";
		arstN = 1'b0;
		inVld = 1'b0;
		sub = 1'b0;
		a = '0;
		b = '0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		testLatency();
		testExact();
		testRounding();
		testExceptions();
		testStream();
		repeat (3) @(posedge clk);
		$display("Errors: %0d wrong values, %0d other failures", valErrs, otherErrs);
		if (valErrs == 0 && otherErrs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- verif/fpAddSub_props.sv
`timescale 1ns/1ps

module fpAddSubProps (
	input logic              clk,
	input logic              arstN,
	input logic              inVld,
	input logic              outVld,
	input fpFormatPkg::halfT y,
	input fpFormatPkg::excT  exc
);

	logic [4:0] vldHist;  // inVld over the last five edges

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vldHist <= '0;
		end else begin
			vldHist <= {vldHist[3:0], inVld};
		end
	end

	assert property (@(posedge clk) disable iff (!arstN) outVld == vldHist[4])
		else $error("outVld does not follow inVld by five cycles");

	// Only the canonical NaN may leave
	assert property (@(posedge clk) disable iff (!arstN)
		outVld |-> (!((&y.exp) && (|y.man)) || y == fpFormatPkg::qNaN))
		else $error("Result is a non-canonical NaN");

	assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown(outVld) && (outVld -> !$isunknown({y, exc})))
		else $error("Unknown value on an output after reset");

endmodule
